/* include/spi_mux_config.svh */
`ifndef SPI_MUX_CONFIG_SVH
`define SPI_MUX_CONFIG_SVH

////////////////////////////////////////////////////////////
// register write frames
////////////////////////////////////////////////////////////

// bits per frame, address byte first then value byte
`define SPI_MUX_FRAME_BITS 16

// register map
`define SPI_MUX_ADDR_LED 8'd7
`define SPI_MUX_ADDR_MUX 8'd8
`define SPI_MUX_ADDR_DAC 8'd9

////////////////////////////////////////////////////////////
// board and timing
////////////////////////////////////////////////////////////

// chip select lanes, only adc, dac and flash wired on the board
`define SPI_MUX_NUM_PERIPH 8

// flops per pin synchronizer
`define SPI_MUX_SYNC_STAGES 2

// log2 of blink prescale, roughly a visible rate off the crystal
`define SPI_MUX_BLINK_LOG2 20

`endif

/* run.sh */
#!/bin/sh
# build and run the testbench, exit status gives pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module spi_mux_tb \
  -o spi_mux_sim

./obj_dir/spi_mux_sim

/* tb.f */
+incdir+include
verilog/spi_mux_pkg.sv
verilog/spi_reg_decoder.sv
verilog/ctrl_regs.sv
verilog/periph_router.sv
verilog/gray_blinker.sv
verilog/spi_mux_top.sv
tests/spi_mux_tb.sv

/* tests/spi_mux_tb.sv */
`timescale 1ns/1ps
`include "spi_mux_config.svh"

module spi_mux_tb;

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  // one register frame and the state it should leave behind
  typedef struct packed {
    logic [4:0] nbits;
    logic       special_n;
    logic [7:0] addr;
    logic [7:0] data;
    logic       corrupt;
    logic [7:0] exp_mux;
    logic [3:0] exp_dac;
    // manual flag, then pattern
    logic [2:0] exp_led;
  } vec_t;

  localparam int num_vec = 14;
  // sclk half period in clk cycles
  localparam int half_sclk = 4;
  // frame, settle, led watch and routing checks, rounded up
  localparam int cycles_per_vec = 300;
  localparam longint limit_ns = longint'(num_vec * cycles_per_vec + 300) * 100;

  string test_names [num_vec] = '{
    "dac write", "unknown addr", "short frame", "long frame",
    "special high", "special mid", "mux write", "mux bad length",
    "mux multi", "led manual", "led manual low", "dac second",
    "led blink", "mux clear"
  };

  vec_t vectors [num_vec] = '{
    '{5'd16, 1'b0, `SPI_MUX_ADDR_DAC, 8'hA5, 1'b0, 8'h00, 4'h5, 3'b000},
    '{5'd16, 1'b0, 8'h0A,             8'hFF, 1'b0, 8'h00, 4'h5, 3'b000},
    '{5'd15, 1'b0, `SPI_MUX_ADDR_DAC, 8'h0C, 1'b0, 8'h00, 4'h5, 3'b000},
    '{5'd17, 1'b0, `SPI_MUX_ADDR_DAC, 8'h0C, 1'b0, 8'h00, 4'h5, 3'b000},
    '{5'd16, 1'b1, `SPI_MUX_ADDR_DAC, 8'h0C, 1'b0, 8'h00, 4'h5, 3'b000},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_DAC, 8'h0C, 1'b1, 8'h00, 4'h5, 3'b000},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_MUX, 8'h05, 1'b0, 8'h05, 4'h5, 3'b000},
    '{5'd15, 1'b0, `SPI_MUX_ADDR_MUX, 8'hFF, 1'b0, 8'h05, 4'h5, 3'b000},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_MUX, 8'h83, 1'b0, 8'h83, 4'h5, 3'b000},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_LED, 8'h82, 1'b0, 8'h83, 4'h5, 3'b110},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_LED, 8'h81, 1'b0, 8'h83, 4'h5, 3'b101},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_DAC, 8'hFA, 1'b0, 8'h83, 4'hA, 3'b101},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_LED, 8'h03, 1'b0, 8'h83, 4'hA, 3'b011},
    '{5'd16, 1'b0, `SPI_MUX_ADDR_MUX, 8'h00, 1'b0, 8'h00, 4'hA, 3'b011}
  };

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     sclk;
  logic                     cs_n;
  logic                     mosi;
  logic                     special_n;
  logic                     miso;
  logic                     periph_sclk;
  logic                     periph_mosi;
  spi_mux_pkg::periph_vec_t periph_cs_n;
  spi_mux_pkg::periph_vec_t periph_miso;
  spi_mux_pkg::dac_ctrl_t   dac_ctrl;
  logic [1:0]               led;

  // register model, written only by valid frames
  logic [7:0]               model_mux;
  logic [3:0]               model_dac;
  logic [2:0]               model_led;
  logic [31:0]              rng_state;
  vec_t                     v;

  spi_mux_top #(
    .blink_log2 (3)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .miso        (miso),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso),
    .dac_ctrl    (dac_ctrl),
    .led         (led)
  );

  // 100 ns period
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // msb first from word[16], 17th bit is a trailing zero
  task automatic send_frame(input logic [4:0] nbits, input logic spec,
                            input logic [16:0] word, input logic corrupt);
    @(posedge clk);
    special_n <= spec;
    sclk <= 1'b0;
    repeat (2) @(posedge clk);
    cs_n <= 1'b0;
    for (int i = 0; i < int'(nbits); i++)
    begin
      repeat (half_sclk) @(posedge clk);
      mosi <= word[16-i];
      sclk <= 1'b0;
      // special released halfway through
      if (corrupt && i == 8)
      begin
        special_n <= 1'b1;
      end
      repeat (half_sclk) @(posedge clk);
      sclk <= 1'b1;
    end
    repeat (half_sclk) @(posedge clk);
    sclk <= 1'b0;
    repeat (half_sclk) @(posedge clk);
    cs_n <= 1'b1;
    // special held past the cs_n rise, then the register settles
    repeat (8) @(posedge clk);
    special_n <= 1'b1;
  endtask

  // every led change flips exactly one bit
  task automatic watch_blink(input string name);
    logic [1:0] prev;
    int         changes;
    @(negedge clk);
    prev = led;
    changes = 0;
    repeat (64)
    begin
      @(negedge clk);
      if (led !== prev)
      begin
        check_value({name, " gray step"}, 32'd1, 32'($countones(led ^ prev)));
        changes++;
      end
      prev = led;
    end
    check_value({name, " blink running"}, 32'd1, 32'(changes >= 4));
  endtask

  task automatic check_routing(input string name, input logic [7:0] mux);
    @(posedge clk);
    cs_n <= 1'b1;
    special_n <= 1'b1;
    @(negedge clk);
    check_value({name, " cs idle"}, 32'hFF, 32'(periph_cs_n));
    @(posedge clk);
    cs_n <= 1'b0;
    @(negedge clk);
    check_value({name, " cs select"}, {24'h0, ~mux}, 32'(periph_cs_n));
    repeat (4)
    begin
      @(posedge clk);
      rng_state = xorshift(rng_state);
      periph_miso <= rng_state[7:0];
      sclk <= rng_state[8];
      mosi <= rng_state[9];
      @(negedge clk);
      check_value({name, " miso"}, 32'(|(rng_state[7:0] & mux)), 32'(miso));
      check_value({name, " sclk fwd"}, 32'(rng_state[8]), 32'(periph_sclk));
      check_value({name, " mosi fwd"}, 32'(rng_state[9]), 32'(periph_mosi));
    end
    // register mode blocks every lane
    @(posedge clk);
    special_n <= 1'b0;
    @(negedge clk);
    check_value({name, " special low"}, 32'hFF, 32'(periph_cs_n));
    @(posedge clk);
    cs_n <= 1'b1;
    sclk <= 1'b0;
    mosi <= 1'b0;
    @(posedge clk);
    special_n <= 1'b1;
    repeat (6) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst_n = 1'b0;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    special_n = 1'b1;
    periph_miso = '0;
    rng_state = 32'hd5cb0db1;
    model_mux = '0;
    model_dac = '0;
    model_led = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    rng_state = xorshift(rng_state);
    periph_miso <= rng_state[7:0];
    @(negedge clk);
    check_value("reset cs", 32'hFF, 32'(periph_cs_n));
    check_value("reset dac", 32'h0, 32'(dac_ctrl));
    check_value("reset miso", 32'h0, 32'(miso));
    check_value("reset led", 32'h0, 32'(led));
    watch_blink("reset");
    for (int n = 0; n < num_vec; n++)
    begin
      v = vectors[n];
      send_frame(v.nbits, v.special_n, {v.addr, v.data, 1'b0}, v.corrupt);
      // frame rule, exact length with special low throughout
      if (v.nbits == 5'd16 && !v.special_n && !v.corrupt)
      begin
        if (v.addr == `SPI_MUX_ADDR_LED)
        begin
          model_led = {v.data[7], v.data[1:0]};
        end
        if (v.addr == `SPI_MUX_ADDR_MUX)
        begin
          model_mux = v.data;
        end
        if (v.addr == `SPI_MUX_ADDR_DAC)
        begin
          model_dac = v.data[3:0];
        end
      end
      @(negedge clk);
      check_value({test_names[n], " model mux"}, 32'(v.exp_mux), 32'(model_mux));
      check_value({test_names[n], " model dac"}, 32'(v.exp_dac), 32'(model_dac));
      check_value({test_names[n], " model led"}, 32'(v.exp_led), 32'(model_led));
      check_value({test_names[n], " dac"}, 32'(model_dac), 32'(dac_ctrl));
      if (model_led[2])
      begin
        check_value({test_names[n], " led"}, 32'(model_led[1:0]), 32'(led));
      end
      else
      begin
        watch_blink(test_names[n]);
      end
      check_routing(test_names[n], model_mux);
    end
    $display("Everything OK");
    $finish;
  end

  // watchdog
  initial
  begin
    #(limit_ns);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* verilog/ctrl_regs.sv */
`timescale 1ns/1ps
`include "spi_mux_config.svh"

module ctrl_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_mux_pkg::reg_write_t  wr,
  output spi_mux_pkg::periph_vec_t mux_sel,
  output spi_mux_pkg::led_ctrl_t   led_ctrl,
  output spi_mux_pkg::dac_ctrl_t   dac_ctrl
);

  spi_mux_pkg::periph_vec_t mux_q;
  spi_mux_pkg::led_ctrl_t   led_q;
  spi_mux_pkg::dac_ctrl_t   dac_q;
  logic                     hit_led;
  logic                     hit_mux;
  logic                     hit_dac;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  assign hit_led = wr.valid && (wr.addr == `SPI_MUX_ADDR_LED);
  assign hit_mux = wr.valid && (wr.addr == `SPI_MUX_ADDR_MUX);
  assign hit_dac = wr.valid && (wr.addr == `SPI_MUX_ADDR_DAC);

  ////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // all chip selects idle, blink mode, dac pins low
      mux_q <= '0;
      led_q <= '0;
      dac_q <= '0;
    end
    else
    begin
      if (hit_mux)
      begin
        mux_q <= wr.data[`SPI_MUX_NUM_PERIPH-1:0];
      end
      if (hit_led)
      begin
        // bit 7 picks manual, bits 1:0 the pattern
        led_q <= '{manual: wr.data[7], pattern: wr.data[1:0]};
      end
      if (hit_dac)
      begin
        // ldac, rst, uni_bip_a, uni_bip_b from bit 0 up
        dac_q <= wr.data[3:0];
      end
    end
  end

  assign mux_sel = mux_q;
  assign led_ctrl = led_q;
  assign dac_ctrl = dac_q;

  // map addresses must stay distinct
  a_one_hit: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({hit_led, hit_mux, hit_dac})
  );

endmodule

/* verilog/gray_blinker.sv */
`timescale 1ns/1ps
`include "spi_mux_config.svh"

module gray_blinker #(
  parameter int log2_delay = `SPI_MUX_BLINK_LOG2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_mux_pkg::led_ctrl_t led_ctrl,
  output logic [1:0]             led
);

  // prescale bits plus two bits of slow count
  logic [log2_delay+1:0] cnt_q;
  logic [1:0]            slow_cnt;
  logic [1:0]            gray_q;

  ////////////////////////////////////////////////////////////
  // slow count and gray encode
  ////////////////////////////////////////////////////////////

  assign slow_cnt = cnt_q[log2_delay +: 2];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
      gray_q <= '0;
    end
    else
    begin
      // free running, wraps silently
      cnt_q <= cnt_q + 1'b1;
      // registered so the pins never glitch
      gray_q <= slow_cnt ^ (slow_cnt >> 1);
    end
  end

  // manual override straight from the register
  assign led = led_ctrl.manual ? led_ctrl.pattern : gray_q;

endmodule

/* verilog/periph_router.sv */
`timescale 1ns/1ps

module periph_router (
  input  logic                     cs_n,
  input  logic                     special_n,
  input  spi_mux_pkg::periph_vec_t mux_sel,
  input  spi_mux_pkg::periph_vec_t periph_miso,
  output spi_mux_pkg::periph_vec_t periph_cs_n,
  output logic                     miso
);

  // bus chip select spread across every lane
  spi_mux_pkg::periph_vec_t cs_fan;

  ////////////////////////////////////////////////////////////
  // chip select fan-out
  ////////////////////////////////////////////////////////////

  // no clock on this path, forwarded bus must not lag the controller
  assign cs_fan = {$bits(spi_mux_pkg::periph_vec_t){~cs_n}};

  always_comb
  begin
    if (special_n)
    begin
      // pass-through, selected lanes follow cs_n
      periph_cs_n = ~(mux_sel & cs_fan);
    end
    else
    begin
      // register frame in flight, keep every peripheral deselected
      periph_cs_n = '1;
    end
  end

  ////////////////////////////////////////////////////////////
  // miso combine
  ////////////////////////////////////////////////////////////

  // unselected lanes masked off
  // several selected lanes just OR together
  assign miso = |(periph_miso & mux_sel);

  // register writes never leak to the peripherals
  always_comb
  begin
    if (!special_n)
    begin
      a_lanes_idle: assert (&periph_cs_n)
      else
        $error("peripheral chip select low during register frame");
    end
  end

endmodule

/* verilog/spi_mux_pkg.sv */
`include "spi_mux_config.svh"

package spi_mux_pkg;

  ////////////////////////////////////////////////////////////
  // plain widths
  ////////////////////////////////////////////////////////////

  // high byte of a frame
  typedef logic [7:0] reg_addr_t;
  // low byte of a frame
  typedef logic [7:0] reg_data_t;
  // one bit per peripheral lane
  typedef logic [`SPI_MUX_NUM_PERIPH-1:0] periph_vec_t;

  ////////////////////////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////////////////////////

  // one decoded write, valid is a single cycle strobe
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    reg_data_t data;
  } reg_write_t;

  // dac control pins, msb first as on the connector
  typedef struct packed {
    logic uni_bip_b;
    logic uni_bip_a;
    logic rst;
    logic ldac;
  } dac_ctrl_t;

  // led register fields, bit 7 and bits 1:0
  typedef struct packed {
    logic       manual;
    logic [1:0] pattern;
  } led_ctrl_t;

  // decoder frame states
  typedef enum logic [1:0] {IDLE, SHIFT, CHECK} dec_state_t;

endpackage

/* verilog/spi_mux_top.sv */
`timescale 1ns/1ps
`include "spi_mux_config.svh"

module spi_mux_top #(
  parameter int blink_log2 = `SPI_MUX_BLINK_LOG2
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // controller spi bus
  input  logic                     sclk,
  input  logic                     cs_n,
  input  logic                     mosi,
  input  logic                     special_n,
  output logic                     miso,

  // peripheral side
  output logic                     periph_sclk,
  output logic                     periph_mosi,
  output spi_mux_pkg::periph_vec_t periph_cs_n,
  input  spi_mux_pkg::periph_vec_t periph_miso,

  // dac control pins
  output spi_mux_pkg::dac_ctrl_t   dac_ctrl,

  // status leds
  output logic [1:0]               led
);

  spi_mux_pkg::reg_write_t  wr;
  spi_mux_pkg::periph_vec_t mux_sel;
  spi_mux_pkg::led_ctrl_t   led_ctrl;

  ////////////////////////////////////////////////////////////
  // register write path
  ////////////////////////////////////////////////////////////

  spi_reg_decoder u_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special_n (special_n),
    .wr        (wr)
  );

  ctrl_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .mux_sel  (mux_sel),
    .led_ctrl (led_ctrl),
    .dac_ctrl (dac_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // pass-through routing
  ////////////////////////////////////////////////////////////

  // clock and data go to every peripheral, only cs picks the target
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  periph_router u_router (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mux_sel     (mux_sel),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  // status leds
  gray_blinker #(
    .log2_delay (blink_log2)
  ) u_blinker (
    .clk      (clk),
    .rst_n    (rst_n),
    .led_ctrl (led_ctrl),
    .led      (led)
  );

endmodule

/* verilog/spi_reg_decoder.sv */
`timescale 1ns/1ps
`include "spi_mux_config.svh"

module spi_reg_decoder (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sclk,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  logic                    special_n,
  output spi_mux_pkg::reg_write_t wr
);

  localparam int frame_bits = `SPI_MUX_FRAME_BITS;
  localparam int sync_stages = `SPI_MUX_SYNC_STAGES;
  // counter holds one past a full frame so 17 bits is still seen as too long
  localparam int cnt_w = $clog2(frame_bits + 2);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(frame_bits + 1);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(frame_bits);

  // controller bus pins, synchronized together
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    logic special_n;
  } pins_t;

  // idle bus levels
  localparam pins_t pins_idle = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0, special_n: 1'b1};

  pins_t                  sync_q [sync_stages];
  pins_t                  pins_s;
  logic                   sclk_prev_q;
  logic                   cs_prev_q;
  logic                   sclk_rise;
  logic                   cs_rise;
  logic                   shift_en;
  spi_mux_pkg::dec_state_t state_q;
  logic [cnt_w-1:0]       cnt_q;
  logic                   bad_q;
  logic                   valid_q;
  logic [frame_bits-1:0]  frame_q;

  ////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < sync_stages; i++)
      begin
        sync_q[i] <= pins_idle;
      end
      sclk_prev_q <= 1'b0;
      cs_prev_q <= 1'b1;
    end
    else
    begin
      sync_q[0] <= '{sclk: sclk, cs_n: cs_n, mosi: mosi, special_n: special_n};
      for (int i = 1; i < sync_stages; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
      sclk_prev_q <= pins_s.sclk;
      cs_prev_q <= pins_s.cs_n;
    end
  end

  assign pins_s = sync_q[sync_stages-1];
  assign sclk_rise = pins_s.sclk & ~sclk_prev_q;
  // end of frame
  assign cs_rise = pins_s.cs_n & ~cs_prev_q;
  // mosi is synchronized alongside sclk, so it lines up with the edge
  assign shift_en = (state_q == spi_mux_pkg::SHIFT) && sclk_rise && !pins_s.special_n;

  ////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= spi_mux_pkg::IDLE;
      cnt_q <= '0;
      bad_q <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      case (state_q)
        spi_mux_pkg::IDLE:
        begin
          // frame opens on cs_n low
          if (!pins_s.cs_n)
          begin
            state_q <= spi_mux_pkg::SHIFT;
            cnt_q <= '0;
            bad_q <= 1'b0;
          end
        end
        spi_mux_pkg::SHIFT:
        begin
          // special released mid frame, whole frame is junk
          if (pins_s.special_n)
          begin
            bad_q <= 1'b1;
          end
          // saturate so long frames never wrap back to 16
          if (shift_en && cnt_q != cnt_max)
          begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (cs_rise)
          begin
            state_q <= spi_mux_pkg::CHECK;
          end
        end
        spi_mux_pkg::CHECK:
        begin
          valid_q <= (cnt_q == cnt_full) && !bad_q;
          state_q <= spi_mux_pkg::IDLE;
        end
        default:
        begin
          state_q <= spi_mux_pkg::IDLE;
        end
      endcase
    end
  end

  // msb first shift
  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      frame_q <= {frame_q[frame_bits-2:0], pins_s.mosi};
    end
  end

  // frame_q holds still until the next frame, well after the strobe
  assign wr = '{valid: valid_q, addr: frame_q[frame_bits-1 -: 8], data: frame_q[7:0]};

  // strobe lasts one cycle
  a_valid_single: assert property (
    @(posedge clk) disable iff (!rst_n) valid_q |=> !valid_q
  );

  // strobe only two cycles after a synchronized cs_n rise
  a_valid_after_rise: assert property (
    @(posedge clk) disable iff (!rst_n) valid_q |-> $past(cs_rise, 2)
  );

endmodule
